// File: src/igr_ppe_pkg.sv
/*
 * ingress to packet-processing subsystem, shared widths and types
 * header fields, result record fields, packet type and lane depths
 */

package igr_ppe_pkg;

  // --------------------------------------------------------------------------
  // sizes
  // --------------------------------------------------------------------------

  // ids in flight, also the reorder window size
  localparam int ID_CNT = 16;
  localparam int ID_W = $clog2(ID_CNT);

  // header destination address
  localparam int DST_W = 12;

  // egress port taken from low dst bits
  localparam int PORT_W = 6;

  // traffic class, same width as header priority
  localparam int TC_W = 3;

  // policer index is port concatenated over tc
  localparam int POLICER_W = PORT_W + TC_W;

  // --------------------------------------------------------------------------
  // lane depths
  // --------------------------------------------------------------------------

  // unicast lookup
  localparam int UC_PIPE_DEPTH = 8;
  // longer multicast lookup
  localparam int MC_PIPE_DEPTH = 12;

  // --------------------------------------------------------------------------
  // field types
  // --------------------------------------------------------------------------

  // sequence id of a header
  typedef logic [ID_W-1:0] pkt_id_t;

  typedef logic [DST_W-1:0] dst_addr_t;

  typedef logic [PORT_W-1:0] port_t;

  typedef logic [TC_W-1:0] tc_t;

  typedef logic [POLICER_W-1:0] policer_idx_t;

  // packet class of a result
  // encoding kept from the full metadata format, MC is zero
  typedef enum logic [3:0] {
    MC = 4'h0,
    UC = 4'h1
  } pkt_type_t;

endpackage : igr_ppe_pkg

// File: src/igr_ppe_if.sv
/*
 * lane result record between a processing pipe and the merge
 */

`timescale 1ns/10ps

interface lane_res_if;

  // strobe, one cycle per result
  logic                      valid;
  // sequence id given at dispatch
  igr_ppe_pkg::pkt_id_t      id;
  igr_ppe_pkg::port_t        port;
  igr_ppe_pkg::tc_t          tc;
  igr_ppe_pkg::policer_idx_t policer_idx;
  igr_ppe_pkg::pkt_type_t    pkt_type;

  // pipe side, builds the record
  modport src (
    output valid,
    output id,
    output port,
    output tc,
    output policer_idx,
    output pkt_type
  );

  // merge side, consumes the record
  modport dst (
    input valid,
    input id,
    input port,
    input tc,
    input policer_idx,
    input pkt_type
  );

endinterface : lane_res_if

// File: src/igr_hdr_dispatch.sv
/*
 * header dispatch, gives each accepted header a sequence id
 * and steers it to the unicast or multicast lane
 */

`timescale 1ns/10ps

module igr_hdr_dispatch (
  input  logic                    cclk,
  input  logic                    rst,

  // incoming header
  input  logic                    hdr_valid,
  input  igr_ppe_pkg::dst_addr_t  hdr_dst,
  input  igr_ppe_pkg::tc_t        hdr_pri,
  input  logic                    hdr_mc,
  output igr_ppe_pkg::pkt_id_t    hdr_id,

  // lane strobes, only one of them per header
  output logic                    uc_valid,
  output logic                    mc_valid,

  // fields shared by both lanes
  output igr_ppe_pkg::pkt_id_t    lane_id,
  output igr_ppe_pkg::dst_addr_t  lane_dst,
  output igr_ppe_pkg::tc_t        lane_pri
);

  // id of the next header to be accepted
  igr_ppe_pkg::pkt_id_t id_cnt;
  igr_ppe_pkg::pkt_id_t id_nxt;

  // --------------------------------------------------------------------------
  // id counter
  // --------------------------------------------------------------------------

  // wrap at the window size
  always_comb begin
    if (id_cnt == igr_ppe_pkg::pkt_id_t'(igr_ppe_pkg::ID_CNT - 1)) begin
      id_nxt = '0;
    end else begin
      id_nxt = id_cnt + 1'b1;
    end
  end

  // advances on the edge after each accepted header
  always_ff @(posedge cclk) begin
    if (rst) begin
      id_cnt <= '0;
    end else if (hdr_valid) begin
      id_cnt <= id_nxt;
    end
  end

  // id seen by the source in the accepting cycle
  assign hdr_id = id_cnt;

  // --------------------------------------------------------------------------
  // lane steering
  // --------------------------------------------------------------------------

  // multicast flag picks the lane
  assign uc_valid = hdr_valid & ~hdr_mc;
  assign mc_valid = hdr_valid & hdr_mc;

  // payload fields fan out to both pipes, the strobe qualifies them
  assign lane_id  = id_cnt;
  assign lane_dst = hdr_dst;
  assign lane_pri = hdr_pri;

endmodule : igr_hdr_dispatch

// File: src/rx_ppe_pipe.sv
/*
 * fixed-depth processing pipe, delays a header DEPTH cycles
 * and turns it into a lane result record
 */

`timescale 1ns/10ps

module rx_ppe_pipe #(
  parameter int DEPTH = 8,
  // lane class, selects the result packet type
  parameter bit IS_MC = 1'b0
) (
  input  logic                    cclk,
  input  logic                    rst,

  // header from dispatch
  input  logic                    in_valid,
  input  igr_ppe_pkg::pkt_id_t    in_id,
  input  igr_ppe_pkg::dst_addr_t  in_dst,
  input  igr_ppe_pkg::tc_t        in_pri,

  // result record toward merge
  lane_res_if.src                 res
);

  // --------------------------------------------------------------------------
  // header queue
  // --------------------------------------------------------------------------

  // stage 0 takes the input, stage DEPTH-1 feeds the result
  logic                   valid_q [DEPTH];
  igr_ppe_pkg::pkt_id_t   id_q    [DEPTH];
  igr_ppe_pkg::dst_addr_t dst_q   [DEPTH];
  igr_ppe_pkg::tc_t       pri_q   [DEPTH];

  // derived fields of the last stage
  igr_ppe_pkg::port_t     out_port;
  igr_ppe_pkg::tc_t       out_tc;

  // whole queue cleared on reset
  always_ff @(posedge cclk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= 1'b0;
        id_q[i]    <= '0;
        dst_q[i]   <= '0;
        pri_q[i]   <= '0;
      end
    end else begin
      valid_q[0] <= in_valid;
      id_q[0]    <= in_id;
      dst_q[0]   <= in_dst;
      pri_q[0]   <= in_pri;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
        id_q[i]    <= id_q[i-1];
        dst_q[i]   <= dst_q[i-1];
        pri_q[i]   <= pri_q[i-1];
      end
    end
  end

  // --------------------------------------------------------------------------
  // result record
  // --------------------------------------------------------------------------

  // egress port is the low part of the destination
  assign out_port = igr_ppe_pkg::port_t'(dst_q[DEPTH-1]);
  // tc follows priority unchanged
  assign out_tc   = pri_q[DEPTH-1];

  assign res.valid       = valid_q[DEPTH-1];
  assign res.id          = id_q[DEPTH-1];
  assign res.port        = out_port;
  assign res.tc          = out_tc;
  // one policer per port and class
  assign res.policer_idx = {out_port, out_tc};
  assign res.pkt_type    = IS_MC ? igr_ppe_pkg::MC : igr_ppe_pkg::UC;

endmodule : rx_ppe_pipe

// File: src/igr_md_merge.sv
/*
 * result merge, reorder window over both lanes
 * releases results in id order, one per cycle
 */

`timescale 1ns/10ps

module igr_md_merge (
  input  logic                       cclk,
  input  logic                       rst,

  // lane results, may arrive in the same cycle
  lane_res_if.dst                    uc_res,
  lane_res_if.dst                    mc_res,

  // in-order result stream
  output logic                       res_valid,
  output igr_ppe_pkg::pkt_id_t       res_id,
  output igr_ppe_pkg::port_t         res_port,
  output igr_ppe_pkg::tc_t           res_tc,
  output igr_ppe_pkg::policer_idx_t  res_policer_idx,
  output igr_ppe_pkg::pkt_type_t     res_pkt_type
);

  // next id to release
  igr_ppe_pkg::pkt_id_t exp_id;

  // window slots, indexed by id
  logic [igr_ppe_pkg::ID_CNT-1:0] slot_full;
  igr_ppe_pkg::port_t             slot_port [igr_ppe_pkg::ID_CNT];
  igr_ppe_pkg::tc_t               slot_tc   [igr_ppe_pkg::ID_CNT];
  igr_ppe_pkg::policer_idx_t      slot_pol  [igr_ppe_pkg::ID_CNT];
  igr_ppe_pkg::pkt_type_t         slot_type [igr_ppe_pkg::ID_CNT];

  // release source this cycle
  logic rel_slot;
  logic rel_uc;
  logic rel_mc;
  logic rel_any;

  // --------------------------------------------------------------------------
  // release select
  // --------------------------------------------------------------------------

  // a stored result has priority, else a lane result at the expected id
  // goes straight to the outputs
  always_comb begin
    rel_slot = slot_full[exp_id];
    rel_uc   = !rel_slot && uc_res.valid && (uc_res.id == exp_id);
    rel_mc   = !rel_slot && mc_res.valid && (mc_res.id == exp_id);
    rel_any  = rel_slot | rel_uc | rel_mc;
  end

  // --------------------------------------------------------------------------
  // window control
  // --------------------------------------------------------------------------

  always_ff @(posedge cclk) begin
    if (rst) begin
      exp_id    <= '0;
      slot_full <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= rel_any;
      // 4-bit id wraps with the window
      if (rel_any) begin
        exp_id <= exp_id + 1'b1;
      end
      if (rel_slot) begin
        slot_full[exp_id] <= 1'b0;
      end
      // park results that are not released now
      // ids in flight are unique, so these never hit the released slot
      if (uc_res.valid && !rel_uc) begin
        slot_full[uc_res.id] <= 1'b1;
      end
      if (mc_res.valid && !rel_mc) begin
        slot_full[mc_res.id] <= 1'b1;
      end
    end
  end

  // slot payload, written on arrival
  always_ff @(posedge cclk) begin
    if (uc_res.valid) begin
      slot_port[uc_res.id] <= uc_res.port;
      slot_tc[uc_res.id]   <= uc_res.tc;
      slot_pol[uc_res.id]  <= uc_res.policer_idx;
      slot_type[uc_res.id] <= uc_res.pkt_type;
    end
    if (mc_res.valid) begin
      slot_port[mc_res.id] <= mc_res.port;
      slot_tc[mc_res.id]   <= mc_res.tc;
      slot_pol[mc_res.id]  <= mc_res.policer_idx;
      slot_type[mc_res.id] <= mc_res.pkt_type;
    end
  end

  // --------------------------------------------------------------------------
  // output record
  // --------------------------------------------------------------------------

  always_ff @(posedge cclk) begin
    res_id <= exp_id;
    if (rel_slot) begin
      res_port        <= slot_port[exp_id];
      res_tc          <= slot_tc[exp_id];
      res_policer_idx <= slot_pol[exp_id];
      res_pkt_type    <= slot_type[exp_id];
    end else if (rel_uc) begin
      res_port        <= uc_res.port;
      res_tc          <= uc_res.tc;
      res_policer_idx <= uc_res.policer_idx;
      res_pkt_type    <= uc_res.pkt_type;
    end else if (rel_mc) begin
      res_port        <= mc_res.port;
      res_tc          <= mc_res.tc;
      res_policer_idx <= mc_res.policer_idx;
      res_pkt_type    <= mc_res.pkt_type;
    end
  end

endmodule : igr_md_merge

// File: src/igr_ppe_top.sv
/*
 * ingress to packet-processing top, dispatch into two lanes
 * of different depth and merge back in id order
 */

`timescale 1ns/10ps

module igr_ppe_top (
  input  logic                       cclk,
  input  logic                       rst,

  // header input, one strobe per header
  input  logic                       hdr_valid,
  input  igr_ppe_pkg::dst_addr_t     hdr_dst,
  input  igr_ppe_pkg::tc_t           hdr_pri,
  input  logic                       hdr_mc,
  output igr_ppe_pkg::pkt_id_t       hdr_id,

  // in-order results
  output logic                       res_valid,
  output igr_ppe_pkg::pkt_id_t       res_id,
  output igr_ppe_pkg::port_t         res_port,
  output igr_ppe_pkg::tc_t           res_tc,
  output igr_ppe_pkg::policer_idx_t  res_policer_idx,
  output igr_ppe_pkg::pkt_type_t     res_pkt_type
);

  // dispatch to pipes
  logic                   uc_valid;
  logic                   mc_valid;
  igr_ppe_pkg::pkt_id_t   lane_id;
  igr_ppe_pkg::dst_addr_t lane_dst;
  igr_ppe_pkg::tc_t       lane_pri;

  // pipe results to merge
  lane_res_if uc_lane ();
  lane_res_if mc_lane ();

  igr_hdr_dispatch dispatch_i (
    .cclk      (cclk),
    .rst       (rst),
    .hdr_valid (hdr_valid),
    .hdr_dst   (hdr_dst),
    .hdr_pri   (hdr_pri),
    .hdr_mc    (hdr_mc),
    .hdr_id    (hdr_id),
    .uc_valid  (uc_valid),
    .mc_valid  (mc_valid),
    .lane_id   (lane_id),
    .lane_dst  (lane_dst),
    .lane_pri  (lane_pri)
  );

  // unicast lane
  rx_ppe_pipe #(
    .DEPTH (igr_ppe_pkg::UC_PIPE_DEPTH),
    .IS_MC (1'b0)
  ) uc_pipe (
    .cclk     (cclk),
    .rst      (rst),
    .in_valid (uc_valid),
    .in_id    (lane_id),
    .in_dst   (lane_dst),
    .in_pri   (lane_pri),
    .res      (uc_lane.src)
  );

  // multicast lane, longer lookup
  rx_ppe_pipe #(
    .DEPTH (igr_ppe_pkg::MC_PIPE_DEPTH),
    .IS_MC (1'b1)
  ) mc_pipe (
    .cclk     (cclk),
    .rst      (rst),
    .in_valid (mc_valid),
    .in_id    (lane_id),
    .in_dst   (lane_dst),
    .in_pri   (lane_pri),
    .res      (mc_lane.src)
  );

  igr_md_merge merge_i (
    .cclk            (cclk),
    .rst             (rst),
    .uc_res          (uc_lane.dst),
    .mc_res          (mc_lane.dst),
    .res_valid       (res_valid),
    .res_id          (res_id),
    .res_port        (res_port),
    .res_tc          (res_tc),
    .res_policer_idx (res_policer_idx),
    .res_pkt_type    (res_pkt_type)
  );

endmodule : igr_ppe_top

// File: tests/igr_ppe_props.sv
/*
 * merge output properties, id order of released results and reset
 */

`timescale 1ns/10ps

module igr_ppe_props (
  input logic                 cclk,
  input logic                 rst,
  input logic                 res_valid,
  input igr_ppe_pkg::pkt_id_t res_id
);

  // id of the last released result
  igr_ppe_pkg::pkt_id_t last_id;
  logic                 seen;

  always_ff @(posedge cclk) begin
    if (rst) begin
      last_id <= '0;
      seen    <= 1'b0;
    end else if (res_valid) begin
      last_id <= res_id;
      seen    <= 1'b1;
    end
  end

  // first result after reset carries id 0
  a_first_id: assert property (@(posedge cclk) disable iff (rst)
    (res_valid && !seen) |-> (res_id == 4'd0))
    else $error("first released id after reset is not zero");

  // each later release is the previous id plus one, wrapping at 16
  a_next_id: assert property (@(posedge cclk) disable iff (rst)
    (res_valid && seen) |-> (res_id == last_id + 4'd1))
    else $error("released id does not follow the previous one");

  // no result strobe while reset is held
  a_rst_quiet: assert property (@(posedge cclk) rst |=> !res_valid)
    else $error("result strobe raised during reset");

endmodule : igr_ppe_props

bind igr_md_merge igr_ppe_props props_i (
  .cclk      (cclk),
  .rst       (rst),
  .res_valid (res_valid),
  .res_id    (res_id)
);

// File: tests/tb_checker.sv
/*
 * result checker that compares in-order results with expected records
 * and the header id against the issue count
 */

`timescale 1ns/10ps

module tb_checker (
  input  logic                      cclk,
  input  logic                      rst,
  input  logic                      hdr_valid,
  input  igr_ppe_pkg::pkt_id_t      hdr_id,
  input  logic                      res_valid,
  input  igr_ppe_pkg::pkt_id_t      res_id,
  input  igr_ppe_pkg::port_t        res_port,
  input  igr_ppe_pkg::tc_t          res_tc,
  input  igr_ppe_pkg::policer_idx_t res_policer_idx,
  input  igr_ppe_pkg::pkt_type_t    res_pkt_type,
  output int                        value_errs,
  output int                        other_errs,
  output int                        pending
);

  // packed expected record per issued header
  logic [33:0] exp_q [$];
  // headers accepted since reset, also the index of the next test
  int          issue_cnt;

  initial begin
    value_errs = 0;
    other_errs = 0;
  end

  assign pending = exp_q.size();

  // called by tb_top once per issued header
  task automatic push_expect(input logic [7:0] idx, input logic [3:0] id,
                             input logic [5:0] port, input logic [2:0] tc,
                             input logic [8:0] pol, input logic [3:0] ptype);
    exp_q.push_back({idx, id, port, tc, pol, ptype});
  endtask

  task automatic compare_field(input string tname, input string field,
                               input logic [15:0] exp_v, input logic [15:0] act_v);
    if (exp_v !== act_v) begin
      $display("Error %s %s expected %0h actual %0h", tname, field, exp_v, act_v);
      value_errs++;
    end
  endtask

  // nothing may remain outstanding at the end of the run
  task automatic final_check();
    if (exp_q.size() != 0) begin
      $display("%0d expected results never came back", exp_q.size());
      other_errs++;
    end
  endtask

  // ------------------------------------------------------------------------
  // sampling on the rising edge with inputs settled in the cycle before
  // ------------------------------------------------------------------------

  always @(posedge cclk) begin
    logic [33:0] e;
    string       tname;
    if (rst) begin
      issue_cnt <= 0;
      if (res_valid === 1'b1) begin
        $display("result strobe raised during reset");
        other_errs++;
      end
    end else begin
      // header id given in the accepting cycle, wrapping at the window size
      if (hdr_valid) begin
        tname = $sformatf("test_%0d", issue_cnt);
        compare_field(tname, "hdr_id", 16'(issue_cnt % igr_ppe_pkg::ID_CNT), 16'(hdr_id));
        issue_cnt <= issue_cnt + 1;
      end
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          $display("result with id %0h arrived with nothing expected", res_id);
          other_errs++;
        end else begin
          e = exp_q.pop_front();
          tname = $sformatf("test_%0d", e[33:26]);
          compare_field(tname, "id", 16'(e[25:22]), 16'(res_id));
          compare_field(tname, "port", 16'(e[21:16]), 16'(res_port));
          compare_field(tname, "tc", 16'(e[15:13]), 16'(res_tc));
          compare_field(tname, "policer_idx", 16'(e[12:4]), 16'(res_policer_idx));
          compare_field(tname, "pkt_type", 16'(e[3:0]), 16'(res_pkt_type));
        end
      end
    end
  end

endmodule : tb_checker

// File: tests/tb_top.sv
/*
 * testbench top, clock and reset, header stimulus from the test file,
 * timeout and closing report
 */

`timescale 1ns/10ps

module tb_top;

  localparam int N_TESTS = 24;
  // values per line of the test file
  localparam int N_COLS = 8;

  logic                      cclk;
  logic                      rst;
  logic                      hdr_valid;
  igr_ppe_pkg::dst_addr_t    hdr_dst;
  igr_ppe_pkg::tc_t          hdr_pri;
  logic                      hdr_mc;
  igr_ppe_pkg::pkt_id_t      hdr_id;
  logic                      res_valid;
  igr_ppe_pkg::pkt_id_t      res_id;
  igr_ppe_pkg::port_t        res_port;
  igr_ppe_pkg::tc_t          res_tc;
  igr_ppe_pkg::policer_idx_t res_policer_idx;
  igr_ppe_pkg::pkt_type_t    res_pkt_type;

  int value_errs;
  int other_errs;
  int pending;

  logic [15:0] test_mem [N_TESTS*N_COLS];
  int          cycle_cnt;
  int          cycle_limit;
  logic [3:0]  exp_id;

  // 20 ns period
  initial cclk = 1'b0;
  always #10 cclk = ~cclk;

  igr_ppe_top igr_ppe_top_i (
    .cclk            (cclk),
    .rst             (rst),
    .hdr_valid       (hdr_valid),
    .hdr_dst         (hdr_dst),
    .hdr_pri         (hdr_pri),
    .hdr_mc          (hdr_mc),
    .hdr_id          (hdr_id),
    .res_valid       (res_valid),
    .res_id          (res_id),
    .res_port        (res_port),
    .res_tc          (res_tc),
    .res_policer_idx (res_policer_idx),
    .res_pkt_type    (res_pkt_type)
  );

  tb_checker tb_checker_i (
    .cclk            (cclk),
    .rst             (rst),
    .hdr_valid       (hdr_valid),
    .hdr_id          (hdr_id),
    .res_valid       (res_valid),
    .res_id          (res_id),
    .res_port        (res_port),
    .res_tc          (res_tc),
    .res_policer_idx (res_policer_idx),
    .res_pkt_type    (res_pkt_type),
    .value_errs      (value_errs),
    .other_errs      (other_errs),
    .pending         (pending)
  );

  // ------------------------------------------------------------------------
  // timeout, counted from reset release
  // ------------------------------------------------------------------------

  always @(posedge cclk) begin
    if (!rst) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("timeout after %0d cycles, %0d results still missing", cycle_cnt, pending);
        $display("Verification failed");
        $finish;
      end
    end
  end

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------

  initial begin
    int b;
    rst       = 1'b1;
    hdr_valid = 1'b0;
    hdr_dst   = '0;
    hdr_pri   = '0;
    hdr_mc    = 1'b0;
    cycle_cnt = 0;
    exp_id    = 4'd0;
    $readmemh("tests/igr_ppe_tests.dat", test_mem);
    // gaps, one cycle per header, the longer lane and some margin
    cycle_limit = N_TESTS + igr_ppe_pkg::MC_PIPE_DEPTH + 20;
    for (int i = 0; i < N_TESTS; i++) begin
      cycle_limit += int'(test_mem[i*N_COLS]);
    end

    repeat (3) @(posedge cclk);
    rst <= 1'b0;

    for (int i = 0; i < N_TESTS; i++) begin
      b = i * N_COLS;
      repeat (int'(test_mem[b])) begin
        @(posedge cclk);
        hdr_valid <= 1'b0;
      end
      @(posedge cclk);
      hdr_valid <= 1'b1;
      hdr_dst   <= test_mem[b+1][11:0];
      hdr_pri   <= test_mem[b+2][2:0];
      hdr_mc    <= test_mem[b+3][0];
      // ids follow issue order and wrap at 16
      tb_checker_i.push_expect(8'(i), exp_id, test_mem[b+4][5:0], test_mem[b+5][2:0],
                               test_mem[b+6][8:0], test_mem[b+7][3:0]);
      exp_id = exp_id + 4'd1;
    end
    @(posedge cclk);
    hdr_valid <= 1'b0;

    // drain, the timeout bounds this loop
    while (pending != 0) begin
      @(posedge cclk);
    end
    // a few extra cycles to catch stray results
    repeat (4) @(posedge cclk);
    tb_checker_i.final_check();

    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_top

// File: tests/igr_ppe_tests.dat
// one test per line: gap dst pri mc | exp_port exp_tc exp_policer_idx exp_pkt_type
// gap counts idle cycles before the header, all values hex
0000 0123 0005 0000  0023 0005 011d 0001
0014 0abc 0002 0001  003c 0002 01e2 0000
0014 0041 0007 0001  0001 0007 000f 0000
0000 0fff 0000 0000  003f 0000 01f8 0001
0000 0080 0003 0000  0000 0003 0003 0001
0000 05a5 0001 0001  0025 0001 0129 0000
0000 03c7 0006 0000  0007 0006 003e 0001
0000 0200 0004 0001  0000 0004 0004 0000
000f 010a 0002 0001  000a 0002 0052 0000
0003 0777 0003 0000  0037 0003 01bb 0001
0014 0001 0001 0000  0001 0001 0009 0001
0000 0002 0002 0001  0002 0002 0012 0000
0000 0003 0003 0000  0003 0003 001b 0001
0000 0004 0004 0000  0004 0004 0024 0001
0000 0805 0005 0001  0005 0005 002d 0000
0000 0806 0006 0000  0006 0006 0036 0001
0000 0907 0007 0001  0007 0007 003f 0000
0000 0908 0000 0000  0008 0000 0040 0001
0000 0a49 0001 0000  0009 0001 0049 0001
0000 0b4a 0002 0001  000a 0002 0052 0000
0000 0c8b 0003 0000  000b 0003 005b 0001
0000 0dcc 0004 0001  000c 0004 0064 0000
0000 0e0d 0005 0000  000d 0005 006d 0001
0000 0f3e 0006 0001  003e 0006 01f6 0000

// File: tb.f
src/igr_ppe_pkg.sv
src/igr_ppe_if.sv
src/igr_hdr_dispatch.sv
src/rx_ppe_pipe.sv
src/igr_md_merge.sv
src/igr_ppe_top.sv
tests/igr_ppe_props.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run.sh
#!/bin/bash
# build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f tb.f -o Vtb_top || exit 1

out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -q "^Verification passed$" && exit 0 || exit 1
